// ==== Makefile ====
# Verilator build, run and lint for the warp address looper

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 --Mdir obj_dir
LINTFLAGS ?= --lint-only --timing
TOP       := tb_accum_warp_looper
FILELIST  := accum_warp_looper.f
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message appears in the output
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== accum_warp_looper.f ====
design/warp_looper_pkg.sv
design/accum_offset_stage.sv
design/accum_memofs_stage.sv
design/accum_vector_stage.sv
design/accum_warp_looper.sv
tb/tb_accum_warp_looper.sv

// ==== design/accum_memofs_stage.sv ====
// Memory offset stage: linear address from block and accumulation offsets
`default_nettype none

module accum_memofs_stage
	import warp_looper_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire cfg_t      i_cfg [N_CFG],
	input  wire logic      i_ofs_rdy,
	output logic           o_ofs_ack,
	input  wire ofs_beat_t i_ofs,
	output logic           o_lin_rdy,
	input  wire logic      i_lin_ack,
	output lin_beat_t      o_lin
);

	cfg_t           cfg;
	logic [ABW-1:0] lin_addr;
	logic           in_fire;

	// ============================================================
	// Address
	// ============================================================
	assign cfg = i_cfg[i_ofs.id];

	// Base plus shifted block and accumulation coordinates
	always_comb begin
		lin_addr = cfg.base;
		for (int d = 0; d < VDIM; d++) begin
			lin_addr = lin_addr + (ABW'(i_ofs.bofs[d]) << cfg.bsh[d]);
			lin_addr = lin_addr + (ABW'(i_ofs.aofs[d]) << cfg.ash[d]);
		end
	end

	// ============================================================
	// Output register
	// ============================================================
	// Take a beat when the register is free or being drained
	assign o_ofs_ack = i_ofs_rdy && (!o_lin_rdy || i_lin_ack);
	assign in_fire   = o_ofs_ack;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_lin_rdy <= 1'b0;
		end else if (in_fire) begin
			o_lin_rdy <= 1'b1;
		end else if (i_lin_ack) begin
			o_lin_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (in_fire) begin
			o_lin.id     <= i_ofs.id;
			o_lin.addr   <= lin_addr;
			o_lin.islast <= i_ofs.islast;
		end
	end

endmodule

`default_nettype wire

// ==== design/accum_offset_stage.sv ====
// Accumulation offset stage: request holding and row-major offset counter
`default_nettype none

module accum_offset_stage
	import warp_looper_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire logic      i_req_rdy,
	output logic           o_req_ack,
	input  wire warp_req_t i_req,
	output logic           o_ofs_rdy,
	input  wire logic      i_ofs_ack,
	output ofs_beat_t      o_ofs
);

	// ============================================================
	// State
	// ============================================================
	logic                     busy;
	warp_req_t                req_q;
	logic [VDIM-1:0][WBW-1:0] cnt_q;

	logic req_empty;
	logic last0;
	logic last1;
	logic islast;
	logic ofs_fire;

	// ============================================================
	// Control
	// ============================================================
	// Empty when any end does not exceed its begin
	assign req_empty = (i_req.aend[0] <= i_req.abeg[0]) ||
		(i_req.aend[1] <= i_req.abeg[1]);

	// New requests only while nothing is held
	assign o_req_ack = i_req_rdy && !busy;
	assign o_ofs_rdy = busy;
	assign ofs_fire  = busy && i_ofs_ack;

	assign last0  = WBW'(cnt_q[0] + 1'b1) == req_q.aend[0];
	assign last1  = WBW'(cnt_q[1] + 1'b1) == req_q.aend[1];
	assign islast = last0 && last1;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy <= 1'b0;
		end else if (o_req_ack) begin
			// Empty ranges are taken and dropped here
			busy <= !req_empty;
		end else if (ofs_fire && islast) begin
			busy <= 1'b0;
		end
	end

	// ============================================================
	// Offset counter
	// ============================================================
	always_ff @(posedge i_clk) begin
		if (o_req_ack) begin
			req_q <= i_req;
			cnt_q <= i_req.abeg;
		end else if (ofs_fire && !islast) begin
			if (last0) begin
				// Wrap the inner dimension and step the outer one
				cnt_q[0] <= req_q.abeg[0];
				cnt_q[1] <= cnt_q[1] + 1'b1;
			end else begin
				cnt_q[0] <= cnt_q[0] + 1'b1;
			end
		end
	end

	// Beat straight from the held request and counter
	always_comb begin
		o_ofs.id     = req_q.id;
		o_ofs.bofs   = req_q.bofs;
		o_ofs.aofs   = cnt_q;
		o_ofs.islast = islast;
	end

endmodule

`default_nettype wire

// ==== design/accum_vector_stage.sv ====
// Vector stage: lane address expansion with boundary valid bits
`default_nettype none

module accum_vector_stage
	import warp_looper_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire cfg_t      i_cfg [N_CFG],
	input  wire logic      i_lin_rdy,
	output logic           o_lin_ack,
	input  wire lin_beat_t i_lin,
	output logic           o_vec_rdy,
	input  wire logic      i_vec_ack,
	output addr_vec_t      o_vec
);

	cfg_t                      cfg;
	logic [VSIZE-1:0][ABW-1:0] lane_addr;
	logic [VSIZE-1:0]          lane_valid;
	logic                      in_fire;

	// ============================================================
	// Lane expansion
	// ============================================================
	// The id rides along so the table lookup happens here again
	assign cfg = i_cfg[i_lin.id];

	always_comb begin
		for (int k = 0; k < VSIZE; k++) begin
			lane_addr[k]  = i_lin.addr + (ABW'(k) << cfg.lane_sh);
			// Out-of-range lanes keep their address, only valid drops
			lane_valid[k] = lane_addr[k] < cfg.boundary;
		end
	end

	// ============================================================
	// Output register
	// ============================================================
	assign o_lin_ack = i_lin_rdy && (!o_vec_rdy || i_vec_ack);
	assign in_fire   = o_lin_ack;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_vec_rdy <= 1'b0;
		end else if (in_fire) begin
			o_vec_rdy <= 1'b1;
		end else if (i_vec_ack) begin
			o_vec_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (in_fire) begin
			o_vec.id     <= i_lin.id;
			o_vec.addr   <= lane_addr;
			o_vec.valid  <= lane_valid;
			o_vec.retire <= i_lin.islast;
		end
	end

endmodule

`default_nettype wire

// ==== design/accum_warp_looper.sv ====
// Warp address looper top level: offset, memory offset and vector stages
`default_nettype none

module accum_warp_looper
	import warp_looper_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_arst_n,
	input  wire cfg_t      i_cfg [N_CFG],
	input  wire logic      i_req_rdy,
	output logic           o_req_ack,
	input  wire warp_req_t i_req,
	output logic           o_addr_rdy,
	input  wire logic      i_addr_ack,
	output addr_vec_t      o_addr
);

	// ============================================================
	// Inter-stage links
	// ============================================================
	logic      ofs_rdy;
	logic      ofs_ack;
	ofs_beat_t ofs;

	logic      lin_rdy;
	logic      lin_ack;
	lin_beat_t lin;

	// ============================================================
	// Stages
	// ============================================================
	accum_offset_stage u_s0_ofs (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_req_rdy (i_req_rdy),
		.o_req_ack (o_req_ack),
		.i_req     (i_req),
		.o_ofs_rdy (ofs_rdy),
		.i_ofs_ack (ofs_ack),
		.o_ofs     (ofs)
	);

	accum_memofs_stage u_s1_mofs (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_cfg     (i_cfg),
		.i_ofs_rdy (ofs_rdy),
		.o_ofs_ack (ofs_ack),
		.i_ofs     (ofs),
		.o_lin_rdy (lin_rdy),
		.i_lin_ack (lin_ack),
		.o_lin     (lin)
	);

	// Last stage drives the output link directly
	accum_vector_stage u_s2_vec (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_cfg     (i_cfg),
		.i_lin_rdy (lin_rdy),
		.o_lin_ack (lin_ack),
		.i_lin     (lin),
		.o_vec_rdy (o_addr_rdy),
		.i_vec_ack (i_addr_ack),
		.o_vec     (o_addr)
	);

endmodule

`default_nettype wire

// ==== design/warp_looper_pkg.sv ====
// Sizes and packed beat types shared by the warp looper stages
`default_nettype none

package warp_looper_pkg;

	// ============================================================
	// Sizes
	// ============================================================
	localparam int WBW    = 8;
	localparam int ABW    = 16;
	localparam int VSIZE  = 4;
	localparam int N_CFG  = 4;
	localparam int CFG_BW = 2;
	localparam int SH_BW  = 3;
	// Two offset dimensions, index 0 is the innermost
	localparam int VDIM   = 2;

	// ============================================================
	// Configuration word
	// ============================================================
	typedef struct packed {
		logic [ABW-1:0]             base;
		logic [VDIM-1:0][SH_BW-1:0] bsh;
		logic [VDIM-1:0][SH_BW-1:0] ash;
		logic [SH_BW-1:0]           lane_sh;
		// Lanes at or above this address are invalid
		logic [ABW-1:0]             boundary;
	} cfg_t;

	// ============================================================
	// Link beats
	// ============================================================
	typedef struct packed {
		logic [CFG_BW-1:0]        id;
		logic [VDIM-1:0][WBW-1:0] bofs;
		logic [VDIM-1:0][WBW-1:0] abeg;
		// Exclusive end per dimension
		logic [VDIM-1:0][WBW-1:0] aend;
	} warp_req_t;

	typedef struct packed {
		logic [CFG_BW-1:0]        id;
		logic [VDIM-1:0][WBW-1:0] bofs;
		logic [VDIM-1:0][WBW-1:0] aofs;
		logic                     islast;
	} ofs_beat_t;

	typedef struct packed {
		logic [CFG_BW-1:0] id;
		logic [ABW-1:0]    addr;
		logic              islast;
	} lin_beat_t;

	typedef struct packed {
		logic [CFG_BW-1:0]           id;
		logic [VSIZE-1:0][ABW-1:0]   addr;
		logic [VSIZE-1:0]            valid;
		logic                        retire;
	} addr_vec_t;

endpackage

`default_nettype wire

// ==== tb/tb_accum_warp_looper.sv ====
// Testbench with pattern file loading, random back-pressure, request driver and output monitor
`default_nettype none

module tb_accum_warp_looper
	import warp_looper_pkg::*;
();

	localparam int REQ_TIMEOUT   = 200;
	localparam int DRAIN_TIMEOUT = 2000;

	logic        clk = 1'b0;
	logic        arst_n;
	cfg_t        cfg_tab [N_CFG];
	logic        req_rdy;
	logic        req_ack;
	warp_req_t   req;
	logic        addr_rdy;
	logic        addr_ack = 1'b0;
	addr_vec_t   addr;

	logic [15:0] lfsr = 16'd11633;
	warp_req_t   req_list [$];
	addr_vec_t   exp_list [$];
	int          rcv_count = 0;
	int          n_fail = 0;
	int          n_other = 0;
	logic        hold_pending = 1'b0;
	addr_vec_t   held_vec;

	accum_warp_looper accum_warp_looper_i (
		.i_clk      (clk),
		.i_arst_n   (arst_n),
		.i_cfg      (cfg_tab),
		.i_req_rdy  (req_rdy),
		.o_req_ack  (req_ack),
		.i_req      (req),
		.o_addr_rdy (addr_rdy),
		.i_addr_ack (addr_ack),
		.o_addr     (addr)
	);

	always #5 clk = ~clk;

	// ============================================================
	// Pattern file
	// ============================================================
	task automatic load_patterns();
		int               fd;
		int               n;
		int               cfg_count;
		logic [8*120-1:0] rest;
		logic [7:0]       tag;
		logic [31:0]      f1, f2, f3, f4, f5, f6, f7;
		warp_req_t        r;
		addr_vec_t        v;
		cfg_count = 0;
		for (int i = 0; i < N_CFG; i++) begin
			cfg_tab[i] = '0;
		end
		fd = $fopen("tb/warp_looper_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file tb/warp_looper_patterns.txt");
			n_other++;
			return;
		end
		while (!$feof(fd)) begin
			tag = 8'h00;
			// Every line starts with its tag character
			n = $fscanf(fd, " %c", tag);
			if (n != 1) begin
				break;
			end
			if (tag == "#") begin
				// Comment lines are skipped whole
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h", f1, f2, f3, f4, f5, f6, f7);
				if (n != 7) begin
					$display("Malformed line in the pattern file");
					n_other++;
					break;
				end
				if (tag == "C" && cfg_count < N_CFG) begin
					cfg_tab[cfg_count].base       = f1[ABW-1:0];
					cfg_tab[cfg_count].bsh[0]     = f2[SH_BW-1:0];
					cfg_tab[cfg_count].bsh[1]     = f3[SH_BW-1:0];
					cfg_tab[cfg_count].ash[0]     = f4[SH_BW-1:0];
					cfg_tab[cfg_count].ash[1]     = f5[SH_BW-1:0];
					cfg_tab[cfg_count].lane_sh    = f6[SH_BW-1:0];
					cfg_tab[cfg_count].boundary   = f7[ABW-1:0];
					cfg_count++;
				end else if (tag == "R") begin
					r.id      = f1[CFG_BW-1:0];
					r.bofs[0] = f2[WBW-1:0];
					r.bofs[1] = f3[WBW-1:0];
					r.abeg[0] = f4[WBW-1:0];
					r.abeg[1] = f5[WBW-1:0];
					r.aend[0] = f6[WBW-1:0];
					r.aend[1] = f7[WBW-1:0];
					req_list.push_back(r);
				end else if (tag == "V") begin
					v.id      = f1[CFG_BW-1:0];
					v.addr[0] = f2[ABW-1:0];
					v.addr[1] = f3[ABW-1:0];
					v.addr[2] = f4[ABW-1:0];
					v.addr[3] = f5[ABW-1:0];
					v.valid   = f6[VSIZE-1:0];
					v.retire  = f7[0];
					exp_list.push_back(v);
				end else begin
					$display("Unknown or surplus line in the pattern file");
					n_other++;
				end
			end
		end
		$fclose(fd);
		if (cfg_count != N_CFG || exp_list.size() == 0) begin
			$display("Pattern file holds %0d configurations and %0d expected vectors",
				cfg_count, exp_list.size());
			n_other++;
		end
	endtask

	// ============================================================
	// Back-pressure
	// ============================================================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One LFSR bit per cycle decides whether the sink takes the vector
	always @(posedge clk) begin
		#1;
		lfsr = lfsr_next(lfsr);
		addr_ack = addr_rdy && lfsr[0];
	end

	// ============================================================
	// Output monitor
	// ============================================================
	task automatic compare_vector(input addr_vec_t got);
		addr_vec_t exp;
		if (rcv_count >= exp_list.size()) begin
			$display("Unexpected extra vector at t=%0t: %h", $time, got);
			n_other++;
			return;
		end
		exp = exp_list[rcv_count];
		if (got.id !== exp.id) begin
			$display("Fail t=%0t o_addr.id (vector %0d): got %0h expected %0h",
				$time, rcv_count, got.id, exp.id);
			n_fail++;
		end
		for (int k = 0; k < VSIZE; k++) begin
			if (got.addr[k] !== exp.addr[k]) begin
				$display("Fail t=%0t o_addr.addr[%0d] (vector %0d): got %h expected %h",
					$time, k, rcv_count, got.addr[k], exp.addr[k]);
				n_fail++;
			end
		end
		if (got.valid !== exp.valid) begin
			$display("Fail t=%0t o_addr.valid (vector %0d): got %b expected %b",
				$time, rcv_count, got.valid, exp.valid);
			n_fail++;
		end
		if (got.retire !== exp.retire) begin
			$display("Fail t=%0t o_addr.retire (vector %0d): got %b expected %b",
				$time, rcv_count, got.retire, exp.retire);
			n_fail++;
		end
		rcv_count++;
	endtask

	// Inputs settle after each rising edge, so mid-cycle values decide the next transfer
	always @(negedge clk) begin
		if (arst_n) begin
			if (hold_pending) begin
				if (!addr_rdy) begin
					$display("o_addr_rdy dropped at t=%0t before the vector was acked", $time);
					n_other++;
				end else if (addr !== held_vec) begin
					$display("Fail t=%0t o_addr: got %h expected %h", $time, addr, held_vec);
					n_fail++;
				end
			end
			if (addr_rdy && addr_ack) begin
				compare_vector(addr);
			end
			hold_pending = addr_rdy && !addr_ack;
			held_vec = addr;
		end
	end

	// ============================================================
	// Request driver
	// ============================================================
	task automatic send_request(input warp_req_t r, input int idx, output logic taken);
		int waited;
		waited = 0;
		taken = 1'b0;
		req_rdy = 1'b1;
		req = r;
		while (!taken && waited < REQ_TIMEOUT) begin
			@(negedge clk);
			taken = req_ack;
			@(posedge clk);
			#1;
			waited++;
		end
		req_rdy = 1'b0;
		if (!taken) begin
			$display("Timeout: request %0d was not accepted within %0d cycles", idx, REQ_TIMEOUT);
			n_other++;
		end
	endtask

	initial begin
		logic taken;
		int   waited;
		arst_n = 1'b0;
		req_rdy = 1'b0;
		req = '0;
		load_patterns();
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;

		// Nothing may move while no request is offered
		for (int c = 0; c < 3; c++) begin
			@(negedge clk);
			if (addr_rdy !== 1'b0) begin
				$display("Fail t=%0t o_addr_rdy: got %b expected 0", $time, addr_rdy);
				n_fail++;
			end
			if (req_ack !== 1'b0) begin
				$display("Fail t=%0t o_req_ack: got %b expected 0", $time, req_ack);
				n_fail++;
			end
		end
		@(posedge clk);
		#1;

		taken = 1'b1;
		for (int i = 0; i < req_list.size() && taken; i++) begin
			send_request(req_list[i], i, taken);
		end

		waited = 0;
		while (rcv_count < exp_list.size() && waited < DRAIN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (rcv_count < exp_list.size()) begin
			$display("Timeout: only %0d of %0d expected vectors arrived",
				rcv_count, exp_list.size());
			n_other++;
		end
		// Window for stray vectors after the last expected one
		repeat (10) @(negedge clk);

		$display("Errors: %0d value mismatches, %0d other failures, %0d of %0d vectors received",
			n_fail, n_other, rcv_count, exp_list.size());
		if (n_fail == 0 && n_other == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/warp_looper_patterns.txt ====
# C base bsh0 bsh1 ash0 ash1 lane_sh boundary
# R id bofs0 bofs1 abeg0 abeg1 aend0 aend1
# V id addr0 addr1 addr2 addr3 valid retire (all fields hex)
C 1000 2 6 0 4 0 ffff
C 2000 1 5 2 5 1 2100
C 0400 3 7 1 3 2 04a0
C fff0 0 4 0 2 3 ffff
# Single offset, then a 3x2 range, then two empty ranges
R 0 03 02 05 01 06 02
R 1 04 01 00 00 03 02
R 2 00 00 04 03 04 05
R 0 00 00 01 02 05 02
# Boundary clipping, address wrap, 2x2 range, fully clipped single
R 2 02 01 03 00 05 01
R 3 0f 00 00 00 01 03
R 0 00 00 02 07 04 09
R 1 00 00 10 07 11 08
V 0 10a1 10a2 10a3 10a4 f 1
V 1 2028 202a 202c 202e f 0
V 1 202c 202e 2030 2032 f 0
V 1 2030 2032 2034 2036 f 0
V 1 2048 204a 204c 204e f 0
V 1 204c 204e 2050 2052 f 0
V 1 2050 2052 2054 2056 f 1
V 2 0496 049a 049e 04a2 7 0
V 2 0498 049c 04a0 04a4 3 1
V 3 ffff 0007 000f 0017 e 0
V 3 0003 000b 0013 001b f 0
V 3 0007 000f 0017 001f f 1
V 0 1072 1073 1074 1075 f 0
V 0 1073 1074 1075 1076 f 0
V 0 1082 1083 1084 1085 f 0
V 0 1083 1084 1085 1086 f 1
V 1 2120 2122 2124 2126 0 1
